// ==== Makefile ====
# Verilator build of the PIC testbench

SIM      := verilator
TOP      := tb_pic
FILELIST := sim.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== pic_bus_regs.sv ====
// Wishbone classic slave with one-cycle ack; master must hold the request until wb_ack
`timescale 1ns/100ps
`default_nettype none

module pic_bus_regs (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  wb_cyc,
   input  wire                  wb_stb,
   input  wire                  wb_we,
   input  wire pic_pkg::bus_addr_t  wb_adr,
   input  wire pic_pkg::bus_data_t  wb_wdata,
   output pic_pkg::bus_data_t   wb_rdata,
   output logic                 wb_ack,
   input  wire pic_pkg::irq_vec_t   irr,
   input  wire pic_pkg::irq_vec_t   isr,
   input  wire pic_pkg::irq_level_t grant_level,
   output pic_pkg::irq_vec_t    imr,
   output logic                 ack_strobe,
   output logic                 eoi_strobe,
   output logic                 eoi_specific,
   output pic_pkg::irq_level_t  eoi_level
);

   logic                 accept;     // New transfer, seen while wb_ack is low
   logic                 wr_accept;
   logic                 rd_accept;
   logic                 cmd_wr;
   logic                 mask_wr;
   logic                 icw1;
   logic                 ocw3;
   pic_pkg::init_state_t init_state;
   pic_pkg::readback_t   readback;
   pic_pkg::bus_data_t   rd_value;

   assign accept    = wb_cyc && wb_stb && !wb_ack;
   assign wr_accept = accept && wb_we;
   assign rd_accept = accept && !wb_we;

   assign cmd_wr  = wr_accept && (wb_adr == pic_pkg::addr_cmd);
   assign mask_wr = wr_accept && (wb_adr == pic_pkg::addr_mask);

   // Command word decode, bits 4:3 pick the word type
   assign icw1 = cmd_wr && wb_wdata[4];
   assign ocw3 = cmd_wr && (wb_wdata[4:3] == 2'b01) && wb_wdata[1];

   assign eoi_strobe   = cmd_wr && (wb_wdata[4:3] == 2'b00) && wb_wdata[5];  // OCW2 EOI
   assign eoi_specific = wb_wdata[6];
   assign eoi_level    = wb_wdata[2:0];

   // Vector read is the acknowledge cycle
   assign ack_strobe = rd_accept && (wb_adr == pic_pkg::addr_vector);

   // Ack one clock after the request is first seen
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= accept;
      end
   end

   // Init sequence and IMR
   always_ff @(posedge clk) begin
      if (rst) begin
         init_state <= pic_pkg::init_icw2;
         imr        <= '0;
      end else if (icw1) begin
         init_state <= pic_pkg::init_icw2;  // Restart init
         imr        <= '0;
      end else if (mask_wr) begin
         case (init_state)
            pic_pkg::init_icw2: init_state <= pic_pkg::init_icw3;  // ICW2 dropped
            pic_pkg::init_icw3: init_state <= pic_pkg::init_done;  // ICW3 dropped
            default:            imr        <= wb_wdata;
         endcase
      end
   end

   // OCW3 readback select
   always_ff @(posedge clk) begin
      if (rst) begin
         readback <= pic_pkg::rb_irr;
      end else if (icw1) begin
         readback <= pic_pkg::rb_irr;
      end else if (ocw3) begin
         readback <= wb_wdata[0] ? pic_pkg::rb_isr : pic_pkg::rb_irr;
      end
   end

   // Read mux
   always_comb begin
      case (wb_adr)
         pic_pkg::addr_cmd:
            rd_value = (readback == pic_pkg::rb_isr) ? isr : irr;
         pic_pkg::addr_mask:
            rd_value = imr;
         pic_pkg::addr_vector:
            rd_value = pic_pkg::vector_base + pic_pkg::bus_data_t'(grant_level);
         default:
            rd_value = '0;
      endcase
   end

   // Read data is valid in the ack cycle only
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         wb_rdata <= rd_value;
      end
   end

   a_ack_in_cycle : assert property (
      @(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb)
   ) else $error("wb_ack outside of a bus cycle");

endmodule

`default_nettype wire

// ==== pic_pkg.sv ====
// Shared by all RTL and the testbench. Eight levels only, no cascade, level 0 is the highest
`default_nettype none

package pic_pkg;

   // Sizes and fixed values
   localparam int num_irq = 8;
   localparam logic [7:0] vector_base = 8'h08;  // High part of every acknowledge vector

   // Bus addresses, address 3 reads zero
   localparam logic [1:0] addr_cmd    = 2'd0;   // ICW1, OCW2, OCW3, IRR/ISR readback
   localparam logic [1:0] addr_mask   = 2'd1;   // Init words, then IMR
   localparam logic [1:0] addr_vector = 2'd2;   // Read is the acknowledge cycle

   // One bit per request level
   typedef logic [num_irq-1:0] irq_vec_t;

   // Level number 0..7
   typedef logic [2:0] irq_level_t;

   // Wishbone address and data
   typedef logic [1:0] bus_addr_t;
   typedef logic [7:0] bus_data_t;

   // Init sequence after reset or ICW1
   typedef enum logic [1:0] {
      init_icw2,   // Next mask write is ICW2
      init_icw3,   // Next mask write is ICW3
      init_done    // Mask writes load IMR
   } init_state_t;

   // OCW3 readback selection on the command address
   typedef enum logic {
      rb_irr,
      rb_isr
   } readback_t;

endpackage

`default_nettype wire

// ==== pic_request_latch.sv ====
// Rising edge on ir sets IRR three clocks later; irr_clear wins over a same-cycle edge
`timescale 1ns/100ps
`default_nettype none

module pic_request_latch (
   input  wire                clk,
   input  wire                rst,
   input  wire pic_pkg::irq_vec_t ir,
   input  wire pic_pkg::irq_vec_t irr_clear,
   output pic_pkg::irq_vec_t  irr
);

   pic_pkg::irq_vec_t sync_1;
   pic_pkg::irq_vec_t sync_2;
   pic_pkg::irq_vec_t ir_prev;  // Synchronized value one clock ago
   pic_pkg::irq_vec_t ir_rise;

   // Two-flop synchronizer, lines are asynchronous to clk
   always_ff @(posedge clk) begin
      if (rst) begin
         sync_1 <= '0;
         sync_2 <= '0;
      end else begin
         sync_1 <= ir;
         sync_2 <= sync_1;
      end
   end

   // Edge detect register
   always_ff @(posedge clk) begin
      if (rst) begin
         ir_prev <= '0;
      end else begin
         ir_prev <= sync_2;
      end
   end

   assign ir_rise = sync_2 & ~ir_prev;

   // Request register
   always_ff @(posedge clk) begin
      if (rst) begin
         irr <= '0;
      end else begin
         irr <= (irr | ir_rise) & ~irr_clear;  // Clear has priority
      end
   end

   // The service block only grants what is latched here
   a_clear_only_set : assert property (
      @(posedge clk) disable iff (rst)
      (irr_clear & ~irr) == '0
   ) else $error("irr_clear on a level that is not requested");

endmodule

`default_nettype wire

// ==== pic_service.sv ====
// Fully nested priority only; no auto-EOI, rotation or special mask. Spurious ack reports level 7
`timescale 1ns/100ps
`default_nettype none

module pic_service (
   input  wire                  clk,
   input  wire                  rst,
   input  wire pic_pkg::irq_vec_t   irr,
   input  wire pic_pkg::irq_vec_t   imr,
   input  wire                  ack_strobe,
   input  wire                  eoi_strobe,
   input  wire                  eoi_specific,
   input  wire pic_pkg::irq_level_t eoi_level,
   output pic_pkg::irq_level_t  grant_level,
   output pic_pkg::irq_vec_t    irr_clear,
   output pic_pkg::irq_vec_t    isr,
   output logic                 int_req
);

   pic_pkg::irq_vec_t   pending;      // Unmasked requests
   logic                pend_valid;
   pic_pkg::irq_level_t pend_level;
   logic                isr_valid;
   pic_pkg::irq_level_t isr_level;    // Highest level in service
   pic_pkg::irq_vec_t   grant_onehot;
   pic_pkg::irq_vec_t   eoi_clear;

   // Lowest set index wins, 7 when the vector is empty
   function automatic pic_pkg::irq_level_t top_level(input pic_pkg::irq_vec_t v);
      pic_pkg::irq_level_t lvl;
      lvl = 3'd7;
      for (int i = pic_pkg::num_irq - 1; i >= 0; i--) begin
         if (v[i]) begin
            lvl = pic_pkg::irq_level_t'(i);
         end
      end
      return lvl;
   endfunction

   function automatic pic_pkg::irq_vec_t level_bit(input pic_pkg::irq_level_t lvl);
      return pic_pkg::irq_vec_t'(1) << lvl;
   endfunction

   assign pending    = irr & ~imr;
   assign pend_valid = |pending;
   assign pend_level = top_level(pending);
   assign isr_valid  = |isr;
   assign isr_level  = top_level(isr);

   // Nothing pending gives the spurious level 7
   assign grant_level = pend_level;

   // Request only beats the in-service level if strictly higher priority
   assign int_req = pend_valid && (!isr_valid || (pend_level < isr_level));

   assign grant_onehot = pend_valid ? level_bit(pend_level) : '0;
   assign irr_clear    = ack_strobe ? grant_onehot : '0;  // Spurious ack clears nothing

   // Specific EOI names its level, non-specific takes the highest in service
   always_comb begin
      eoi_clear = '0;
      if (eoi_strobe) begin
         if (eoi_specific) begin
            eoi_clear = level_bit(eoi_level);
         end else if (isr_valid) begin
            eoi_clear = level_bit(isr_level);
         end
      end
   end

   // In-service register
   always_ff @(posedge clk) begin
      if (rst) begin
         isr <= '0;
      end else begin
         isr <= (isr & ~eoi_clear) | irr_clear;
      end
   end

   a_clear_onehot : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(irr_clear)
   ) else $error("irr_clear has more than one bit set");

   // New in-service bits come only from an acknowledge cycle on the bus
   a_isr_needs_ack : assert property (
      @(posedge clk) disable iff (rst)
      !ack_strobe |=> (isr & ~$past(isr)) == '0
   ) else $error("ISR gained a bit without an acknowledge");

endmodule

`default_nettype wire

// ==== pic_top.sv ====
// 8259-style controller top; acknowledge is a Wishbone read of address 2, no cascade or inta_n
`timescale 1ns/100ps
`default_nettype none

module pic_top (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 wb_cyc,
   input  wire                 wb_stb,
   input  wire                 wb_we,
   input  wire pic_pkg::bus_addr_t wb_adr,
   input  wire pic_pkg::bus_data_t wb_wdata,
   output pic_pkg::bus_data_t  wb_rdata,
   output logic                wb_ack,
   input  wire pic_pkg::irq_vec_t  ir,
   output logic                int_req
);

   wire pic_pkg::irq_vec_t   irr;
   wire pic_pkg::irq_vec_t   irr_clear;   // One-hot on a real grant
   wire pic_pkg::irq_vec_t   imr;
   wire pic_pkg::irq_vec_t   isr;
   wire pic_pkg::irq_level_t grant_level;
   wire                      ack_strobe;
   wire                      eoi_strobe;
   wire                      eoi_specific;
   wire pic_pkg::irq_level_t eoi_level;

   // Edge capture of the request pins
   pic_request_latch i_request_latch (
      .clk       (clk),
      .rst       (rst),
      .ir        (ir),
      .irr_clear (irr_clear),
      .irr       (irr)
   );

   pic_service i_service (
      .clk          (clk),
      .rst          (rst),
      .irr          (irr),
      .imr          (imr),
      .ack_strobe   (ack_strobe),
      .eoi_strobe   (eoi_strobe),
      .eoi_specific (eoi_specific),
      .eoi_level    (eoi_level),
      .grant_level  (grant_level),
      .irr_clear    (irr_clear),
      .isr          (isr),
      .int_req      (int_req)
   );

   // Bus side and programmable registers
   pic_bus_regs i_bus_regs (
      .clk          (clk),
      .rst          (rst),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_wdata     (wb_wdata),
      .wb_rdata     (wb_rdata),
      .wb_ack       (wb_ack),
      .irr          (irr),
      .isr          (isr),
      .grant_level  (grant_level),
      .imr          (imr),
      .ack_strobe   (ack_strobe),
      .eoi_strobe   (eoi_strobe),
      .eoi_specific (eoi_specific),
      .eoi_level    (eoi_level)
   );

endmodule

`default_nettype wire

// ==== sim.f ====
pic_pkg.sv
pic_request_latch.sv
pic_service.sv
pic_bus_regs.sv
pic_top.sv
tb_pic.sv

// ==== tb_pic.sv ====
// Table-driven test of pic_top; stops at the first mismatch, needs a simulator with timing support
`timescale 1ns/100ps
`default_nettype none

module tb_pic;

   localparam int clk_period = 8;
   localparam int ack_limit  = 4;    // Cycles to wait for wb_ack
   localparam int int_limit  = 16;   // Cycles to wait for int_req
   localparam int ir_settle  = 4;    // 2 sync stages plus edge register, one spare

   // Command words
   localparam pic_pkg::bus_data_t cmd_icw1     = 8'h11;
   localparam pic_pkg::bus_data_t cmd_ocw3_irr = 8'h0A;
   localparam pic_pkg::bus_data_t cmd_ocw3_isr = 8'h0B;
   localparam pic_pkg::bus_data_t cmd_eoi      = 8'h20;  // Non-specific
   localparam pic_pkg::bus_data_t cmd_eoi_spec = 8'h60;  // Level in bits 2:0

   typedef enum logic [2:0] {
      op_write,
      op_read,      // Data column holds the expected read value
      op_set_ir,
      op_clr_ir,
      op_wait_int   // Data bit 0 is the expected int_req
   } step_op_t;

   logic               clk;
   logic               rst;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   pic_pkg::bus_addr_t wb_adr;
   pic_pkg::bus_data_t wb_wdata;
   pic_pkg::bus_data_t wb_rdata;
   logic               wb_ack;
   pic_pkg::irq_vec_t  ir;
   logic               int_req;

   // Step table
   step_op_t           tbl_op[$];
   pic_pkg::bus_addr_t tbl_adr[$];
   pic_pkg::bus_data_t tbl_data[$];
   logic               table_ready;

   pic_top i_pic_top (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack),
      .ir       (ir),
      .int_req  (int_req)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic end_with_failure();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%02h, expected 0x%02h", name, actual, expected);
         end_with_failure();
      end
   endtask

   task automatic add_step(input step_op_t op, input pic_pkg::bus_addr_t adr,
                           input pic_pkg::bus_data_t data);
      tbl_op.push_back(op);
      tbl_adr.push_back(adr);
      tbl_data.push_back(data);
   endtask

   task automatic build_table();
      // After reset
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h00);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h00);
      // Init words after reset are swallowed
      add_step(op_write,    pic_pkg::addr_mask,   8'hAA);
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
      add_step(op_write,    pic_pkg::addr_mask,   8'h55);
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
      add_step(op_write,    pic_pkg::addr_mask,   8'h3C);
      add_step(op_read,     pic_pkg::addr_mask,   8'h3C);
      // ICW1 restarts init and clears IMR
      add_step(op_write,    pic_pkg::addr_cmd,    cmd_icw1);
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
      add_step(op_write,    pic_pkg::addr_mask,   8'hFF);
      add_step(op_write,    pic_pkg::addr_mask,   8'hFF);
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
      add_step(op_write,    pic_pkg::addr_mask,   8'h20);  // Mask level 5
      add_step(op_read,     pic_pkg::addr_mask,   8'h20);
      // Masked request is latched but quiet
      add_step(op_set_ir,   pic_pkg::addr_cmd,    8'h20);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h20);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h00);
      add_step(op_write,    pic_pkg::addr_mask,   8'h00);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h01);
      // Acknowledge with levels 2 and 5 pending
      add_step(op_set_ir,   pic_pkg::addr_cmd,    8'h04);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h24);
      add_step(op_read,     pic_pkg::addr_vector, 8'h0A);  // Base 0x08, level 2
      add_step(op_read,     pic_pkg::addr_cmd,    8'h20);
      add_step(op_write,    pic_pkg::addr_cmd,    cmd_ocw3_isr);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h04);
      // Nesting, 5 is blocked by 2 and 1 is not
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h00);
      add_step(op_set_ir,   pic_pkg::addr_cmd,    8'h02);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h01);
      add_step(op_read,     pic_pkg::addr_vector, 8'h09);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h06);
      add_step(op_write,    pic_pkg::addr_cmd,    cmd_eoi);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h04);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h00);
      add_step(op_write,    pic_pkg::addr_cmd,    cmd_eoi_spec | 8'h02);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h00);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h01);
      // Take level 5, then a spurious acknowledge
      add_step(op_read,     pic_pkg::addr_vector, 8'h0D);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h20);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h00);
      add_step(op_read,     pic_pkg::addr_vector, 8'h0F);  // Spurious, level 7
      add_step(op_read,     pic_pkg::addr_cmd,    8'h20);
      add_step(op_write,    pic_pkg::addr_cmd,    cmd_ocw3_irr);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h00);
      // Held lines give no new request, a fresh edge does
      add_step(op_clr_ir,   pic_pkg::addr_cmd,    8'h26);
      add_step(op_read,     pic_pkg::addr_cmd,    8'h00);
      add_step(op_set_ir,   pic_pkg::addr_cmd,    8'h08);
      add_step(op_wait_int, pic_pkg::addr_cmd,    8'h01);  // Level 3 beats 5 in service
      add_step(op_read,     pic_pkg::addr_cmd,    8'h08);
      add_step(op_read,     pic_pkg::addr_mask,   8'h00);
   endtask

   // One Wishbone classic transfer, ends 1 ns after an edge
   task automatic bus_transfer(input logic we, input pic_pkg::bus_addr_t adr,
                               input pic_pkg::bus_data_t wdata,
                               output pic_pkg::bus_data_t rdata);
      int cycles;
      cycles   = 0;
      rdata    = '0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_wdata = wdata;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!wb_ack && cycles < ack_limit);
      if (!wb_ack) begin
         $display("No wb_ack within %0d cycles of a request to address %0d", ack_limit, adr);
         end_with_failure();
      end
      rdata = wb_rdata;
      @(posedge clk);  // Master samples wb_ack on this edge
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      check_value("wb_ack", {7'b0, wb_ack}, 8'h00);  // Exactly one ack per transfer
   endtask

   task automatic drive_ir(input pic_pkg::irq_vec_t value);
      ir = value;
      repeat (ir_settle) @(posedge clk);
      #1;
   endtask

   task automatic wait_int_req(input logic expected);
      int cycles;
      cycles = 0;
      while (int_req !== expected && cycles < int_limit) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      check_value("int_req", {7'b0, int_req}, {7'b0, expected});
   endtask

   initial begin
      pic_pkg::bus_data_t rdata;
      clk         = 1'b0;
      rst         = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_wdata    = '0;
      ir          = '0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;

      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int i = 0; i < tbl_op.size(); i++) begin
         case (tbl_op[i])
            op_write: bus_transfer(1'b1, tbl_adr[i], tbl_data[i], rdata);
            op_read: begin
               bus_transfer(1'b0, tbl_adr[i], 8'h00, rdata);
               check_value($sformatf("wb_rdata at address %0d", tbl_adr[i]), rdata,
                           tbl_data[i]);
            end
            op_set_ir:   drive_ir(ir | tbl_data[i]);
            op_clr_ir:   drive_ir(ir & ~tbl_data[i]);
            op_wait_int: wait_int_req(tbl_data[i][0]);
            default: ;
         endcase
      end

      $display("*** PASSED ***");
      $finish;
   end

   // Watchdog, 20 cycles per step plus reset
   initial begin
      int limit_ns;
      wait (table_ready);
      limit_ns = (tbl_op.size() * 20 + 2) * clk_period;
      #(limit_ns);
      $display("Timeout, the step table did not finish within %0d ns", limit_ns);
      end_with_failure();
   end

endmodule

`default_nettype wire
